// File: hdl/lsq_buffer.sv
`timescale 1ns/100ps
`include "lsq_config.svh"

module lsq_buffer
    import lsq_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    lsq_entry_if.sink   entry,
    input  logic        cdb_valid,
    input  tag_t        cdb_tag,
    input  word_t       cdb_value,
    input  logic        store_commit,
    lsq_mem_if.buffer   mem,
    output logic        credit_return
);

    localparam int DEPTH = `LSQ_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    logic [DEPTH-1:0] busy;
    mem_op_t          op           [DEPTH];
    load_funct_t      funct        [DEPTH];
    word_t            base         [DEPTH];
    tag_t             base_tag     [DEPTH];
    word_t            data         [DEPTH];
    tag_t             data_tag     [DEPTH];
    word_t            offset       [DEPTH];
    tag_t             dest         [DEPTH];
    store_cnt_t       store_before [DEPTH];

    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] load_sel;
    logic [IDX_W-1:0] store_sel;
    logic [IDX_W-1:0] load_idx;
    logic [IDX_W-1:0] load_cur;
    logic             load_found;
    logic             store_found;
    logic             load_active;
    logic             new_base_hit;
    logic             new_data_hit;

    // first free slot, credits guarantee one exists on entry.valid
    always_comb begin
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    // lowest index wins for both loads and stores
    always_comb begin
        load_found  = 1'b0;
        load_sel    = '0;
        store_found = 1'b0;
        store_sel   = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (busy[i] && op[i] == op_load && base_tag[i] == '0 &&
                store_before[i] == '0) begin
                load_found = 1'b1;
                load_sel   = IDX_W'(i);
            end
            if (busy[i] && op[i] == op_store && base_tag[i] == '0 && data_tag[i] == '0) begin
                store_found = 1'b1;
                store_sel   = IDX_W'(i);
            end
        end
    end

    // issued load stays offered until the port completes it
    assign load_cur = load_active ? load_idx : load_sel;

    assign mem.load_req   = load_active || load_found;
    assign mem.load_addr  = base[load_cur] + offset[load_cur];
    assign mem.load_funct = funct[load_cur];
    assign mem.load_dest  = dest[load_cur];

    assign mem.store_req  = store_found;
    assign mem.store_addr = base[store_sel] + offset[store_sel];
    assign mem.store_data = data[store_sel];
    assign mem.store_dest = dest[store_sel];

    // one entry at most frees per cycle, the port never grants beside load_done
    assign credit_return = (mem.load_done || mem.store_grant) && !flush;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy        <= '0;
            load_active <= 1'b0;
        end else begin
            if (entry.valid) begin
                busy[free_idx] <= 1'b1;
            end
            if (mem.load_done) begin
                busy[load_idx] <= 1'b0;
                load_active    <= 1'b0;
            end else if (load_found && !load_active) begin
                load_active <= 1'b1;
            end
            if (mem.store_grant) begin
                busy[store_sel] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!load_active) begin
            load_idx <= load_sel;
        end
    end

    // the entry in flight from dispatch can still see a broadcast
    assign new_base_hit = cdb_valid && entry.base_tag != '0 && cdb_tag == entry.base_tag;
    assign new_data_hit = cdb_valid && entry.data_tag != '0 && cdb_tag == entry.data_tag;

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (entry.valid && free_idx == IDX_W'(i)) begin
                op[i]       <= entry.op;
                funct[i]    <= entry.funct;
                offset[i]   <= entry.offset;
                dest[i]     <= entry.dest;
                base[i]     <= new_base_hit ? cdb_value : entry.base;
                base_tag[i] <= new_base_hit ? tag_t'(0) : entry.base_tag;
                data[i]     <= new_data_hit ? cdb_value : entry.data;
                data_tag[i] <= new_data_hit ? tag_t'(0) : entry.data_tag;
                if (store_commit && entry.store_before != '0) begin
                    store_before[i] <= entry.store_before - store_cnt_t'(1);
                end else begin
                    store_before[i] <= entry.store_before;
                end
            end else begin
                // wakeup
                if (cdb_valid && base_tag[i] != '0 && cdb_tag == base_tag[i]) begin
                    base[i]     <= cdb_value;
                    base_tag[i] <= '0;
                end
                if (cdb_valid && data_tag[i] != '0 && cdb_tag == data_tag[i]) begin
                    data[i]     <= cdb_value;
                    data_tag[i] <= '0;
                end
                if (store_commit && busy[i] && op[i] == op_load && store_before[i] != '0) begin
                    store_before[i] <= store_before[i] - store_cnt_t'(1);
                end
            end
        end
    end

endmodule

// File: hdl/lsq_dispatch.sv
`timescale 1ns/100ps

module lsq_dispatch
    import lsq_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        dispatch_valid,
    input  logic        dispatch_is_store,
    input  logic [2:0]  dispatch_funct,
    input  word_t       dispatch_base,
    input  tag_t        dispatch_base_tag,
    input  word_t       dispatch_data,
    input  tag_t        dispatch_data_tag,
    input  word_t       dispatch_offset,
    input  tag_t        dispatch_dest,
    input  logic        cdb_valid,
    input  tag_t        cdb_tag,
    input  word_t       cdb_value,
    input  logic        store_commit,
    lsq_entry_if.source entry
);

    load_funct_t funct_dec;
    store_cnt_t  store_cnt;
    store_cnt_t  store_cnt_net;
    logic        base_hit;
    logic        data_hit;

    // funct3 to load function, unknown codes fall back to a word access
    always_comb begin
        case (dispatch_funct)
            3'b000:  funct_dec = lb;
            3'b001:  funct_dec = lh;
            3'b100:  funct_dec = lbu;
            3'b101:  funct_dec = lhu;
            default: funct_dec = lw;
        endcase
    end

    // operand broadcast in the dispatch cycle itself
    assign base_hit = cdb_valid && dispatch_base_tag != '0 && cdb_tag == dispatch_base_tag;
    assign data_hit = cdb_valid && dispatch_data_tag != '0 && cdb_tag == dispatch_data_tag;

    // stores older than this cycle's dispatch, less a commit now
    always_comb begin
        store_cnt_net = store_cnt;
        if (store_commit && store_cnt != '0) begin
            store_cnt_net = store_cnt - store_cnt_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            entry.valid <= 1'b0;
            store_cnt   <= '0;
        end else begin
            entry.valid <= dispatch_valid;
            if (dispatch_valid && dispatch_is_store) begin
                store_cnt <= store_cnt_net + store_cnt_t'(1);
            end else begin
                store_cnt <= store_cnt_net;
            end
        end
    end

    always_ff @(posedge clk) begin
        entry.op     <= dispatch_is_store ? op_store : op_load;
        entry.funct  <= funct_dec;
        entry.offset <= dispatch_offset;
        entry.dest   <= dispatch_dest;
        entry.base     <= base_hit ? cdb_value : dispatch_base;
        entry.base_tag <= base_hit ? tag_t'(0) : dispatch_base_tag;
        entry.data     <= data_hit ? cdb_value : dispatch_data;
        entry.data_tag <= data_hit ? tag_t'(0) : dispatch_data_tag;
        // Stores never wait on older stores
        entry.store_before <= dispatch_is_store ? store_cnt_t'(0) : store_cnt_net;
    end

endmodule

// File: hdl/lsq_entry_if.sv
`timescale 1ns/100ps

interface lsq_entry_if
    import lsq_pkg::*;
();

    logic        valid;
    mem_op_t     op;
    load_funct_t funct;
    word_t       base;
    tag_t        base_tag;
    word_t       data;
    tag_t        data_tag;
    word_t       offset;
    tag_t        dest;
    // older stores still waiting for commit, loads only
    store_cnt_t  store_before;

    modport source (
        output valid, op, funct, base, base_tag, data, data_tag, offset, dest,
        output store_before
    );

    modport sink (
        input valid, op, funct, base, base_tag, data, data_tag, offset, dest,
        input store_before
    );

endinterface

// File: hdl/lsq_mem_if.sv
`timescale 1ns/100ps

interface lsq_mem_if
    import lsq_pkg::*;
();

    // load side, held by the buffer until load_done
    logic        load_req;
    word_t       load_addr;
    load_funct_t load_funct;
    tag_t        load_dest;
    logic        load_done;

    // store side, one cycle grant
    logic        store_req;
    word_t       store_addr;
    word_t       store_data;
    tag_t        store_dest;
    logic        store_grant;

    modport buffer (
        output load_req, load_addr, load_funct, load_dest,
        input  load_done,
        output store_req, store_addr, store_data, store_dest,
        input  store_grant
    );

    modport port (
        input  load_req, load_addr, load_funct, load_dest,
        output load_done,
        input  store_req, store_addr, store_data, store_dest,
        output store_grant
    );

endinterface

// File: hdl/lsq_mem_port.sv
`timescale 1ns/100ps

module lsq_mem_port
    import lsq_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    lsq_mem_if.port   mem,
    output logic      mem_read,
    output word_t     mem_address,
    input  logic      mem_resp,
    input  word_t     mem_rdata,
    output logic      result_valid,
    output logic      result_is_store,
    output tag_t      result_tag,
    output word_t     result_value,
    output word_t     result_address
);

    port_state_t state;
    word_t       load_value;

    // pick byte or halfword by the low address bits, then extend
    function automatic word_t align_load(word_t raw, logic [1:0] lsb, load_funct_t fn);
        logic [7:0]  byte_val;
        logic [15:0] half_val;
        byte_val = raw[{lsb, 3'b000} +: 8];
        half_val = lsb[1] ? raw[31:16] : raw[15:0];
        case (fn)
            lb:      return {{24{byte_val[7]}}, byte_val};
            lbu:     return {24'b0, byte_val};
            lh:      return {{16{half_val[15]}}, half_val};
            lhu:     return {16'b0, half_val};
            default: return raw;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (mem.load_req) begin
                        state <= wait_resp;
                    end
                end
                wait_resp: begin
                    if (mem_resp) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // address is held by the buffer for the whole request
    assign mem_read    = state == wait_resp;
    assign mem_address = mem.load_addr;

    assign mem.load_done   = state == wait_resp && mem_resp;
    assign mem.store_grant = mem.store_req && !mem.load_done;

    assign load_value = align_load(mem_rdata, mem.load_addr[1:0], mem.load_funct);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= mem.load_done || mem.store_grant;
        end
    end

    // completing load takes the result port ahead of any store
    always_ff @(posedge clk) begin
        if (mem.load_done) begin
            result_is_store <= 1'b0;
            result_tag      <= mem.load_dest;
            result_value    <= load_value;
            result_address  <= mem.load_addr;
        end else if (mem.store_grant) begin
            result_is_store <= 1'b1;
            result_tag      <= mem.store_dest;
            result_value    <= mem.store_data;
            result_address  <= mem.store_addr;
        end
    end

endmodule

// File: hdl/lsq_pkg.sv
package lsq_pkg;

    `include "lsq_config.svh"

    typedef logic [31:0] word_t;
    typedef logic [`LSQ_TAG_WIDTH-1:0] tag_t;
    typedef logic [`LSQ_STORE_CNT_WIDTH-1:0] store_cnt_t;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_t;

    // RV32I funct3 encodings of the loads
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct_t;

    // load side of the memory port
    typedef enum logic {
        idle      = 1'b0,
        wait_resp = 1'b1
    } port_state_t;

endpackage

// File: hdl/lsq_top.sv
`timescale 1ns/100ps

module lsq_top
    import lsq_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       dispatch_valid,
    input  logic       dispatch_is_store,
    input  logic [2:0] dispatch_funct,
    input  word_t      dispatch_base,
    input  tag_t       dispatch_base_tag,
    input  word_t      dispatch_data,
    input  tag_t       dispatch_data_tag,
    input  word_t      dispatch_offset,
    input  tag_t       dispatch_dest,
    output logic       credit_return,
    input  logic       cdb_valid,
    input  tag_t       cdb_tag,
    input  word_t      cdb_value,
    input  logic       store_commit,
    output logic       mem_read,
    output word_t      mem_address,
    input  logic       mem_resp,
    input  word_t      mem_rdata,
    output logic       result_valid,
    output logic       result_is_store,
    output tag_t       result_tag,
    output word_t      result_value,
    output word_t      result_address
);

    lsq_entry_if entry_bus ();
    lsq_mem_if   mem_bus ();

    lsq_dispatch u_dispatch (
        .clk               (clk),
        .rst               (rst),
        .flush             (flush),
        .dispatch_valid    (dispatch_valid),
        .dispatch_is_store (dispatch_is_store),
        .dispatch_funct    (dispatch_funct),
        .dispatch_base     (dispatch_base),
        .dispatch_base_tag (dispatch_base_tag),
        .dispatch_data     (dispatch_data),
        .dispatch_data_tag (dispatch_data_tag),
        .dispatch_offset   (dispatch_offset),
        .dispatch_dest     (dispatch_dest),
        .cdb_valid         (cdb_valid),
        .cdb_tag           (cdb_tag),
        .cdb_value         (cdb_value),
        .store_commit      (store_commit),
        .entry             (entry_bus.source)
    );

    lsq_buffer u_buffer (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .entry         (entry_bus.sink),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .store_commit  (store_commit),
        .mem           (mem_bus.buffer),
        .credit_return (credit_return)
    );

    lsq_mem_port u_mem_port (
        .clk             (clk),
        .rst             (rst),
        .flush           (flush),
        .mem             (mem_bus.port),
        .mem_read        (mem_read),
        .mem_address     (mem_address),
        .mem_resp        (mem_resp),
        .mem_rdata       (mem_rdata),
        .result_valid    (result_valid),
        .result_is_store (result_is_store),
        .result_tag      (result_tag),
        .result_value    (result_value),
        .result_address  (result_address)
    );

endmodule

// File: include/lsq_config.svh
`ifndef LSQ_CONFIG_SVH
`define LSQ_CONFIG_SVH

// reservation entries, also the credits held by the sender after reset
`define LSQ_DEPTH 4

// reorder-buffer tag width, tag 0 means the value is already present
`define LSQ_TAG_WIDTH 3

// width of the uncommitted older-store counters
`define LSQ_STORE_CNT_WIDTH 3

`endif

// File: sim.f
+incdir+include
hdl/lsq_pkg.sv
hdl/lsq_entry_if.sv
hdl/lsq_mem_if.sv
hdl/lsq_dispatch.sv
hdl/lsq_buffer.sv
hdl/lsq_mem_port.sv
hdl/lsq_top.sv
test/lsq_mem_model.sv
test/lsq_tb.sv

// File: test/lsq_mem_model.sv
`timescale 1ns/100ps

module lsq_mem_model #(
    parameter logic [31:0] SEED = 32'h2e6eebce
) (
    input  logic        clk,
    input  logic        mem_read,
    input  logic [31:0] mem_address,
    output logic        mem_resp,
    output logic [31:0] mem_rdata
);

    integer seed;
    int     wait_left;
    logic   busy;

    initial begin
        seed      = SEED;
        mem_resp  = 1'b0;
        mem_rdata = '0;
        busy      = 1'b0;
        wait_left = 0;
    end

    // one request at a time, answered 1 to 4 cycles after mem_read rises
    always @(posedge clk) begin
        #1;
        mem_resp = 1'b0;
        if (!mem_read) begin
            busy = 1'b0;
        end else if (!busy) begin
            busy      = 1'b1;
            wait_left = 1 + ({$random(seed)} % 4);
        end else begin
            wait_left = wait_left - 1;
            if (wait_left == 0) begin
                mem_resp  = 1'b1;
                // word index of the address, scrambled
                mem_rdata = {2'b00, mem_address[31:2]} ^ 32'ha5c3_961e;
                busy      = 1'b0;
            end
        end
    end

endmodule

// File: test/lsq_tb.sv
`timescale 1ns/100ps
`include "lsq_config.svh"

module lsq_tb
    import lsq_pkg::*;
();

    localparam int DEPTH = `LSQ_DEPTH;
    localparam int NTAG  = 1 << `LSQ_TAG_WIDTH;
    localparam int LIMIT = 200;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       flush = 1'b0;
    logic       dispatch_valid = 1'b0;
    logic       dispatch_is_store = 1'b0;
    logic [2:0] dispatch_funct = 3'b010;
    word_t      dispatch_base = '0;
    word_t      dispatch_data = '0;
    word_t      dispatch_offset = '0;
    tag_t       dispatch_base_tag = '0;
    tag_t       dispatch_data_tag = '0;
    tag_t       dispatch_dest = '0;
    logic       cdb_valid = 1'b0;
    tag_t       cdb_tag = '0;
    word_t      cdb_value = '0;
    logic       store_commit = 1'b0;
    logic       credit_return;
    logic       mem_read;
    logic       mem_resp;
    logic       result_valid;
    logic       result_is_store;
    word_t      mem_address;
    word_t      mem_rdata;
    word_t      result_value;
    word_t      result_address;
    tag_t       result_tag;

    // scoreboard indexed by destination tag
    logic [NTAG-1:0] pending;
    logic            exp_store [NTAG];
    word_t           exp_value [NTAG];
    word_t           exp_addr  [NTAG];
    int              load_wait [NTAG];
    tag_t            wait_base [NTAG];
    tag_t            wait_data [NTAG];

    int         credits;
    int         store_out;
    int         ready_commits;
    int         errors = 0;
    int         timeouts = 0;
    integer     seed = 32'h2e6eebce;
    tag_t       next_dest = 1;
    logic       commit_hold = 1'b0;
    logic       hold_now;
    logic       quiet = 1'b0;
    logic       early_read;
    logic       early_result;
    logic [2:0] codes [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};

    always #10 clk = ~clk;

    lsq_top DUT (.*);

    lsq_mem_model #(.SEED(32'h2e6eebce)) mem_model (
        .clk         (clk),
        .mem_read    (mem_read),
        .mem_address (mem_address),
        .mem_resp    (mem_resp),
        .mem_rdata   (mem_rdata)
    );

    // reorder buffer stand-in that commits finished stores unless held
    always @(posedge clk) begin
        hold_now = commit_hold;
        #1;
        store_commit = !hold_now && ready_commits > 0;
    end

    always @(posedge clk) begin
        quiet <= flush ? 1'b1 : (dispatch_valid ? 1'b0 : quiet);
        if (rst || flush) begin
            credits       <= DEPTH;
            store_out     <= 0;
            ready_commits <= 0;
            pending       <= '0;
            for (int t = 0; t < NTAG; t++) begin
                load_wait[t] <= 0;
                wait_base[t] <= '0;
                wait_data[t] <= '0;
            end
        end else begin
            credits   <= credits - int'(dispatch_valid) + int'(credit_return);
            store_out <= store_out + int'(dispatch_valid && dispatch_is_store)
                         - int'(store_commit);
            ready_commits <= ready_commits + int'(result_valid && result_is_store)
                             - int'(store_commit);
            for (int t = 0; t < NTAG; t++) begin
                if (store_commit && load_wait[t] > 0) begin
                    load_wait[t] <= load_wait[t] - 1;
                end
                if (cdb_valid && wait_base[t] == cdb_tag) begin
                    wait_base[t] <= '0;
                end
                if (cdb_valid && wait_data[t] == cdb_tag) begin
                    wait_data[t] <= '0;
                end
            end
            if (result_valid) begin
                pending[result_tag] <= 1'b0;
            end
            if (dispatch_valid) begin
                pending[dispatch_dest]   <= 1'b1;
                load_wait[dispatch_dest] <= dispatch_is_store ? 0
                                            : store_out - int'(store_commit);
                // a broadcast in the dispatch cycle already resolves the operand
                wait_base[dispatch_dest] <= (cdb_valid && cdb_tag == dispatch_base_tag)
                                            ? tag_t'(0) : dispatch_base_tag;
                wait_data[dispatch_dest] <= (cdb_valid && cdb_tag == dispatch_data_tag)
                                            ? tag_t'(0) : dispatch_data_tag;
            end
        end
    end

    always_comb begin
        early_read = 1'b0;
        for (int t = 1; t < NTAG; t++) begin
            if (pending[t] && !exp_store[t] && load_wait[t] != 0 && mem_read &&
                mem_address == exp_addr[t]) begin
                early_read = 1'b1;
            end
        end
        early_result = result_valid &&
                       (wait_base[result_tag] != '0 || wait_data[result_tag] != '0);
    end

    task automatic report_mismatch(input string name, input word_t expected,
                                   input word_t actual);
        errors++;
        $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    assert property (@(posedge clk) disable iff (rst) credits >= 0 && credits <= DEPTH)
        else begin
            errors++;
            $display("%0t: credit count %0d left the range 0..%0d", $time,
                     $sampled(credits), DEPTH);
        end
    assert property (@(posedge clk) disable iff (rst) result_valid |-> pending[result_tag])
        else begin
            errors++;
            $display("%0t: result for tag %0d with no outstanding entry", $time,
                     $sampled(result_tag));
        end
    assert property (@(posedge clk) disable iff (rst)
                     result_valid |-> result_is_store == exp_store[result_tag])
        else report_mismatch("result_is_store", $sampled(exp_store[result_tag]),
                             $sampled(result_is_store));
    assert property (@(posedge clk) disable iff (rst)
                     result_valid |-> result_value == exp_value[result_tag])
        else report_mismatch("result_value", $sampled(exp_value[result_tag]),
                             $sampled(result_value));
    assert property (@(posedge clk) disable iff (rst)
                     result_valid |-> result_address == exp_addr[result_tag])
        else report_mismatch("result_address", $sampled(exp_addr[result_tag]),
                             $sampled(result_address));
    assert property (@(posedge clk) disable iff (rst) !early_result)
        else begin
            errors++;
            $display("%0t: result came before its operand was broadcast", $time);
        end
    assert property (@(posedge clk) disable iff (rst) !early_read)
        else begin
            errors++;
            $display("%0t: load read memory before an older store committed", $time);
        end
    assert property (@(posedge clk) disable iff (rst) quiet |-> !result_valid && !mem_read)
        else begin
            errors++;
            $display("%0t: activity after flush before any new dispatch", $time);
        end

    // addressed byte or halfword of the model word, extended per funct3
    function automatic word_t expect_load(input word_t addr, input logic [2:0] funct);
        word_t w;
        word_t shifted;
        w       = {2'b00, addr[31:2]} ^ 32'ha5c3_961e;
        shifted = w >> (8 * addr[1:0]);
        case (funct)
            3'b000:  return {{24{shifted[7]}}, shifted[7:0]};
            3'b100:  return shifted & 32'h0000_00ff;
            3'b001:  return {{16{shifted[15]}}, shifted[15:0]};
            3'b101:  return shifted & 32'h0000_ffff;
            default: return w;
        endcase
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send(input logic is_store, input logic [2:0] funct, input word_t base,
                        input tag_t base_tag, input word_t data, input tag_t data_tag,
                        input word_t offset, output tag_t dest);
        int waited;
        waited = 0;
        dest   = next_dest;
        while ((credits == 0 || pending[dest]) && waited < LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (credits == 0 || pending[dest]) begin
            timeouts++;
            $display("%0t: no credit or free tag for a dispatch", $time);
        end
        next_dest = (next_dest == tag_t'(NTAG - 1)) ? tag_t'(1) : next_dest + tag_t'(1);
        exp_store[dest] = is_store;
        exp_addr[dest]  = base + offset;
        exp_value[dest] = is_store ? data : expect_load(base + offset, funct);
        dispatch_valid    = 1'b1;
        dispatch_is_store = is_store;
        dispatch_funct    = funct;
        // tagged operands carry a stale value until the CDB replaces it
        dispatch_base     = base_tag != '0 ? ~base : base;
        dispatch_base_tag = base_tag;
        dispatch_data     = data_tag != '0 ? ~data : data;
        dispatch_data_tag = data_tag;
        dispatch_offset   = offset;
        dispatch_dest     = dest;
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
        cdb_valid      = 1'b0;
    endtask

    task automatic broadcast(input tag_t tag, input word_t value);
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        cdb_value = value;
        @(posedge clk);
        #1;
        cdb_valid = 1'b0;
    endtask

    task automatic wait_clear(input logic [NTAG-1:0] mask, input logic stores_too);
        int waited;
        waited = 0;
        while (((pending & mask) != '0 || (stores_too && store_out != 0)) && waited < LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if ((pending & mask) != '0 || (stores_too && store_out != 0)) begin
            timeouts++;
            $display("%0t: outstanding work did not finish", $time);
        end
    endtask

    task automatic drain();
        wait_clear('1, 1'b1);
        assert (credits == DEPTH)
            else report_mismatch("credits", DEPTH, credits);
    endtask

    initial begin
        tag_t       d;
        tag_t       st;
        logic [2:0] f;
        word_t      off;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < 3; i++) begin
            send(1'b1, 3'b010, 32'h1000 + 32'(i * 16), '0, 32'hc0de_0000 + 32'(i), '0,
                 32'(i * 4), d);
        end
        drain();

        // every load width at each legal byte offset
        for (int fi = 0; fi < 5; fi++) begin
            for (int o = 0; o < 4; o++) begin
                f = codes[fi];
                if ((f == 3'b010 && o != 0) || (f[0] && o[0])) begin
                    continue;
                end
                send(1'b0, f, $random(seed) & 32'h0000_fffc, '0, '0, '0, 32'(o), d);
            end
        end
        drain();

        // late operands in the buffer, in flight from dispatch and in the dispatch cycle
        send(1'b0, 3'b000, 32'h0000_2340, 3'd5, '0, '0, 32'h3, d);
        idle(5);
        broadcast(3'd5, 32'h0000_2340);
        send(1'b1, 3'b010, 32'h0000_3000, 3'd6, 32'h1234_5678, 3'd7, 32'h8, d);
        broadcast(3'd6, 32'h0000_3000);
        idle(4);
        broadcast(3'd7, 32'h1234_5678);
        cdb_valid = 1'b1;
        cdb_tag   = 3'd4;
        cdb_value = 32'h0000_4442;
        send(1'b0, 3'b101, 32'h0000_4442, 3'd4, '0, '0, '0, d);
        drain();

        // load held behind a store that finishes but has not committed
        commit_hold = 1'b1;
        send(1'b1, 3'b010, 32'h0000_5000, '0, 32'h0bad_cafe, 3'd3, '0, st);
        send(1'b0, 3'b010, 32'h0000_5100, '0, '0, '0, '0, d);
        idle(6);
        broadcast(3'd3, 32'h0bad_cafe);
        wait_clear(NTAG'(1) << st, 1'b0);
        idle(6);
        commit_hold = 1'b0;
        drain();

        // flush with stores stuck on operands and loads in flight
        for (int i = 0; i < 3; i++) begin
            send(1'(i), 3'b010, 32'h0000_6000 + 32'(i * 8), '0, 32'(i), i[0] ? 3'd2 : 3'd0,
                 '0, d);
        end
        flush = 1'b1;
        idle(1);
        flush = 1'b0;
        idle(6);
        assert (credits == DEPTH)
            else report_mismatch("credits", DEPTH, credits);
        for (int i = 0; i < DEPTH; i++) begin
            send(1'b0, 3'b100, 32'h0000_7000, '0, '0, '0, 32'(i), d);
        end
        drain();

        // random mix with ready operands
        for (int i = 0; i < 16; i++) begin
            f   = codes[{$random(seed)} % 5];
            off = {$random(seed)} % 16;
            if (f == 3'b010) begin
                off[1:0] = 2'b00;
            end else if (f[0]) begin
                off[0] = 1'b0;
            end
            send(1'($random(seed)), f, $random(seed) & 32'h000f_fffc, '0, $random(seed), '0,
                 off, d);
        end
        drain();

        idle(2);
        $display("check failures: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
